/* flist.f */
hw/fetch_pkg.sv
hw/fetch_predecode.sv
hw/fetch_icache.sv
hw/fetch_ctrl.sv
hw/fetch_queue.sv
hw/fetch_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_model.sv
testbench/tb_fetch_unit.sv

/* hw/fetch_ctrl.sv */
`default_nettype none

module fetch_ctrl
    import fetch_pkg::*;
#(
    parameter logic [31:0] RESET_PC = fetch_pkg::RESET_PC
) (
    input  logic        clk,
    input  logic        rst,
    input  redirect_t   redirect,
    output logic        lookup_valid,
    output logic [31:0] lookup_pc,
    input  logic        hit_valid,
    input  logic [31:0] hit_data,
    output logic        cancel,
    output logic        push,
    output fetch_pkt_t  push_pkt,
    input  logic        full,
    output logic        flush
);

    typedef enum logic [1:0] {S_LOOKUP, S_WAIT, S_FULL, S_STALL} state_t;

    state_t      state;
    logic [31:0] pc;
    logic [31:0] hold_data;
    logic [31:0] word;
    logic        hit_take;
    pred_t       pred;

    assign hit_take = (state == S_WAIT) && hit_valid;

    // Held word while the queue is full.
    assign word = (state == S_FULL) ? hold_data : hit_data;

    fetch_predecode u_predecode (
        .instr (word),
        .pc    (pc),
        .pred  (pred)
    );

    assign lookup_pc = pc;
    assign cancel    = redirect.valid;
    assign flush     = redirect.valid;

    assign push     = (hit_take || state == S_FULL) && !full && !redirect.valid;
    assign push_pkt = '{
        pc:    pc,
        instr: pred.is_compressed ? {16'h0, word[15:0]} : word
    };

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // PC and state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= S_LOOKUP;
            pc           <= RESET_PC;
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= 1'b0;
            if (redirect.valid) begin
                // Redirect wins, also out of a stall.
                pc           <= redirect.target;
                state        <= S_WAIT;
                lookup_valid <= 1'b1;
            end else if (push) begin
                pc <= pred.next_pc;
                if (pred.stall) begin
                    state <= S_STALL;
                end else begin
                    state        <= S_WAIT;
                    lookup_valid <= 1'b1;
                end
            end else begin
                case (state)
                    S_LOOKUP: begin
                        state        <= S_WAIT;
                        lookup_valid <= 1'b1;
                    end
                    S_WAIT: begin
                        if (hit_valid) begin
                            state <= S_FULL;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_take) begin
            hold_data <= hit_data;
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

    // Nothing from before a redirect can reach the queue.
    a_no_push_after_redirect: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> !push);

endmodule

`default_nettype wire

/* hw/fetch_icache.sv */
`default_nettype none

module fetch_icache
    import fetch_pkg::*;
#(
    parameter int CACHE_ENTRIES = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        lookup_valid,
    input  logic [31:0] lookup_pc,
    output logic        hit_valid,
    output logic [31:0] hit_data,
    input  logic        cancel,
    output logic        mem_req,
    output mem_req_t    mem_addr,
    input  logic        mem_ack,
    input  logic [31:0] mem_data
);

    localparam int IDX_W = $clog2(CACHE_ENTRIES);
    localparam int TAG_W = 31 - IDX_W;

    typedef enum logic [1:0] {C_IDLE, C_REQ, C_DROP} cstate_t;

    cstate_t                  state;
    logic [CACHE_ENTRIES-1:0] valid_bits;
    logic [TAG_W-1:0]         tag_mem [CACHE_ENTRIES];
    logic [31:0]              data_mem [CACHE_ENTRIES];

    logic             pend;
    logic             cancelled;
    logic [IDX_W-1:0] look_idx;
    logic [IDX_W-1:0] miss_idx;
    logic [TAG_W-1:0] look_tag;
    logic             hit;
    logic             start;
    logic             fill;

    // Halfword granular index.
    assign look_idx = lookup_pc[IDX_W:1];
    assign look_tag = lookup_pc[31:IDX_W+1];
    assign miss_idx = mem_addr.addr[IDX_W:1];

    assign hit   = valid_bits[look_idx] && (tag_mem[look_idx] == look_tag);
    assign start = (state == C_IDLE) && (lookup_valid || pend) && !cancel;
    assign fill  = (state == C_REQ) && mem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= C_IDLE;
            valid_bits <= '0;
            hit_valid  <= 1'b0;
            mem_req    <= 1'b0;
            pend       <= 1'b0;
            cancelled  <= 1'b0;
        end else begin
            hit_valid <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (start) begin
                        pend <= 1'b0;
                        if (hit) begin
                            hit_valid <= 1'b1;
                        end else begin
                            mem_req   <= 1'b1;
                            cancelled <= 1'b0;
                            state     <= C_REQ;
                        end
                    end else if (cancel) begin
                        pend <= 1'b0;
                    end
                end
                C_REQ: begin
                    if (mem_ack) begin
                        mem_req              <= 1'b0;
                        valid_bits[miss_idx] <= 1'b1;
                        state                <= C_DROP;
                    end
                end
                C_DROP: begin
                    // Ack low again, the port is free.
                    if (!mem_ack) begin
                        hit_valid <= !cancelled && !cancel;
                        state     <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase

            // Lookups seen while busy are served once the miss ends.
            if (state != C_IDLE) begin
                if (cancel) begin
                    cancelled <= 1'b1;
                    pend      <= 1'b0;
                end else if (lookup_valid) begin
                    pend <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[miss_idx]  <= mem_addr.addr[31:IDX_W+1];
            data_mem[miss_idx] <= mem_data;
            hit_data           <= mem_data;
        end else if (start && hit) begin
            hit_data <= data_mem[look_idx];
        end
        if (start && !hit) begin
            mem_addr.addr <= lookup_pc;
        end
    end

    a_req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> !mem_ack);

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req && $past(mem_req) |-> mem_addr == $past(mem_addr));

endmodule

`default_nettype wire

/* hw/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Packets and bundles.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        is_compressed;
        logic        stall;
        logic [31:0] next_pc;
    } pred_t;

    localparam logic [31:0] RESET_PC = 32'h0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // Compressed quadrants and funct3.
    localparam logic [1:0] C_Q1 = 2'b01;
    localparam logic [1:0] C_Q2 = 2'b10;

    localparam logic [2:0] C_F3_JAL  = 3'b001;
    localparam logic [2:0] C_F3_J    = 3'b101;
    localparam logic [2:0] C_F3_BEQZ = 3'b110;
    localparam logic [2:0] C_F3_BNEZ = 3'b111;
    localparam logic [2:0] C_F3_JR   = 3'b100;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Immediates, sign extended.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] imm_j(input logic [31:0] i);
        return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] imm_b(input logic [31:0] i);
        return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    endfunction

    // offset[11|4|9:8|10|6|7|3:1|5] in bits 12..2.
    function automatic logic [31:0] imm_cj(input logic [31:0] i);
        return {{21{i[12]}}, i[8], i[10:9], i[6], i[7], i[2], i[11], i[5:3], 1'b0};
    endfunction

    function automatic logic [31:0] imm_cb(input logic [31:0] i);
        return {{24{i[12]}}, i[6:5], i[2], i[11:10], i[4:3], 1'b0};
    endfunction

endpackage

`default_nettype wire

/* hw/fetch_predecode.sv */
`default_nettype none

module fetch_predecode
    import fetch_pkg::*;
(
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    output pred_t       pred
);

    logic [6:0]  opcode;
    logic [1:0]  quad;
    logic [2:0]  funct3_c;
    logic [4:0]  rs1_c;
    logic [4:0]  rs2_c;
    logic        compressed;
    logic [31:0] seq_pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field extraction.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode   = instr[6:0];
    assign quad     = instr[1:0];
    assign funct3_c = instr[15:13];
    assign rs1_c    = instr[11:7];
    assign rs2_c    = instr[6:2];

    // Anything not ending in 11 is a 16-bit form.
    assign compressed = (quad != 2'b11);
    assign seq_pc     = pc + (compressed ? 32'd2 : 32'd4);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Static prediction.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        pred.is_compressed = compressed;
        pred.stall         = 1'b0;
        pred.next_pc       = seq_pc;

        if (!compressed) begin
            case (opcode)
                OP_JAL: begin
                    pred.next_pc = pc + imm_j(instr);
                end
                // Branches are always predicted taken.
                OP_BRANCH: begin
                    pred.next_pc = pc + imm_b(instr);
                end
                OP_JALR: begin
                    pred.stall = 1'b1;
                end
                default: begin
                end
            endcase
        end else if (quad == C_Q1) begin
            case (funct3_c)
                C_F3_J, C_F3_JAL: begin
                    pred.next_pc = pc + imm_cj(instr);
                end
                C_F3_BEQZ, C_F3_BNEZ: begin
                    pred.next_pc = pc + imm_cb(instr);
                end
                default: begin
                end
            endcase
        end else if (quad == C_Q2 && funct3_c == C_F3_JR) begin
            // C.JR and C.JALR. rs1 of zero is reserved or EBREAK.
            if (rs2_c == 5'd0 && rs1_c != 5'd0) begin
                pred.stall = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_queue.sv */
`default_nettype none

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  fetch_pkt_t push_pkt,
    output logic       full,
    input  logic       flush,
    output logic       out_valid,
    output fetch_pkt_t out_pkt,
    input  logic       out_ready
);

    localparam int PW = $clog2(QUEUE_DEPTH);
    localparam logic [PW:0] DEPTH_C = (PW+1)'(QUEUE_DEPTH);

    fetch_pkt_t      mem [QUEUE_DEPTH];
    logic [PW-1:0]   head;
    logic [PW-1:0]   tail;
    logic [PW:0]     count;
    logic            pop;

    assign full      = (count == DEPTH_C);
    assign out_valid = (count != '0);
    assign out_pkt   = mem[head];
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= push_pkt;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= DEPTH_C);

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready && !flush |=> out_valid && $stable(out_pkt));

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
#(
    parameter int          CACHE_ENTRIES = 32,
    parameter int          QUEUE_DEPTH   = 4,
    parameter logic [31:0] RESET_PC      = fetch_pkg::RESET_PC
) (
    input  logic        clk,
    input  logic        rst,
    input  redirect_t   redirect,
    output logic        mem_req,
    output mem_req_t    mem_addr,
    input  logic        mem_ack,
    input  logic [31:0] mem_data,
    output logic        out_valid,
    output fetch_pkt_t  out_pkt,
    input  logic        out_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal nets.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic        lookup_valid;
    logic [31:0] lookup_pc;
    logic        hit_valid;
    logic [31:0] hit_data;
    logic        cancel;
    logic        push;
    fetch_pkt_t  push_pkt;
    logic        full;
    logic        flush;

    fetch_ctrl #(
        .RESET_PC (RESET_PC)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .hit_valid    (hit_valid),
        .hit_data     (hit_data),
        .cancel       (cancel),
        .push         (push),
        .push_pkt     (push_pkt),
        .full         (full),
        .flush        (flush)
    );

    fetch_icache #(
        .CACHE_ENTRIES (CACHE_ENTRIES)
    ) u_icache (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_pc    (lookup_pc),
        .hit_valid    (hit_valid),
        .hit_data     (hit_data),
        .cancel       (cancel),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_data     (mem_data)
    );

    // Decoder side queue.
    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_pkt  (push_pkt),
        .full      (full),
        .flush     (flush),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a rising edge.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tb_fetch_unit.sv */
`default_nettype none

module tb_fetch_unit
    import fetch_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int          CACHE_ENTRIES = 32;
    localparam int          QUEUE_DEPTH   = 4;
    localparam logic [31:0] START_PC      = 32'h0000_0100;
    localparam int          N_PKTS        = 400;
    localparam int          N_RAND_REDIR  = 40;
    localparam int          STALL_IDLE    = 50;
    // Every packet can end in at most one stall redirect.
    localparam int          MAX_REDIRECTS = N_RAND_REDIR + N_PKTS;
    localparam int          WATCHDOG_CYC  = N_PKTS * 40 + MAX_REDIRECTS * 60;

    logic        clk;
    logic        rst;
    redirect_t   redirect;
    logic        mem_req;
    mem_req_t    mem_addr;
    logic        mem_ack;
    logic [31:0] mem_data;
    logic [31:0] mem_word;
    logic        out_valid;
    fetch_pkt_t  out_pkt;
    logic        out_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory contents and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [31:0] h;
        logic [31:0] w;
        h = addr * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        h = h * 32'h85eb_ca6b;
        h = h ^ (h >> 13);
        w = h;
        case (h[31:28])
            4'd8: begin
                w[1:0]   = 2'b01;
                w[15:13] = 3'b000;
            end
            4'd9:  w[6:0] = OP_JAL;
            4'd10: w[6:0] = OP_BRANCH;
            4'd11: w[6:0] = OP_JALR;
            4'd12: begin
                w[1:0]   = 2'b01;
                w[15:13] = h[27] ? 3'b101 : 3'b001;
            end
            4'd13: begin
                w[1:0]   = 2'b01;
                w[15:13] = h[27] ? 3'b111 : 3'b110;
            end
            4'd14: begin
                // Indirect jump when rs2 is zero, else a register move or add.
                w[1:0]   = 2'b10;
                w[15:13] = 3'b100;
                w[11:7]  = {h[26:23], 1'b1};
                w[6:2]   = h[27] ? 5'd0 : {h[22:19], 1'b1};
            end
            4'd15: begin
                w[1:0]   = 2'b10;
                w[15:13] = 3'b010;
            end
            default: w[6:0] = h[27] ? 7'b0110011 : 7'b0010011;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] model_next_pc(input logic [31:0] pc,
                                                  input logic [31:0] w,
                                                  output logic stall);
        logic        is_c;
        logic [31:0] nxt;
        is_c  = (w[1:0] != 2'b11);
        nxt   = pc + (is_c ? 32'd2 : 32'd4);
        stall = 1'b0;
        if (!is_c) begin
            case (w[6:0])
                OP_JAL:    nxt = pc + imm_j(w);
                OP_BRANCH: nxt = pc + imm_b(w);
                OP_JALR:   stall = 1'b1;
                default:   ;
            endcase
        end else if (w[1:0] == 2'b01 && w[15:13] inside {3'b001, 3'b101}) begin
            nxt = pc + imm_cj(w);
        end else if (w[1:0] == 2'b01 && w[15:14] == 2'b11) begin
            nxt = pc + imm_cb(w);
        end else if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && w[6:2] == 5'd0
                     && w[11:7] != 5'd0) begin
            stall = 1'b1;
        end
        return nxt;
    endfunction

    // Small pool so that targets are revisited.
    function automatic logic [31:0] pick_target();
        logic [31:0] t;
        case ($urandom_range(3, 0))
            0:       t = START_PC;
            1:       t = 32'h0000_0400;
            2:       t = 32'h0002_0036;
            default: t = 32'h0000_0400 + 2 * $urandom_range(7, 0);
        endcase
        return t;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_val(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instances.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign mem_word = word_at(mem_addr.addr);

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (16)
    ) u_clk (
        .clk (clk),
        .rst (rst)
    );

    tb_mem_model #(
        .MAX_DELAY (5)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .addr_word (mem_word),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data)
    );

    fetch_unit #(
        .CACHE_ENTRIES (CACHE_ENTRIES),
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .RESET_PC      (START_PC)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus and checking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int unsigned accepted;
        int unsigned rand_redirs;
        int unsigned idle;
        logic [31:0] exp_pc;
        logic [31:0] exp_instr;
        logic [31:0] w;
        logic        stalled;
        logic        stall;
        logic        fire;
        fetch_pkt_t  pkt;
        redirect_t   rd;

        void'($urandom(32'h8ba5));
        redirect    = '0;
        out_ready   = 1'b0;
        accepted    = 0;
        rand_redirs = 0;
        idle        = 0;
        exp_pc      = START_PC;
        stalled     = 1'b0;

        @(negedge clk);
        compare_val("reset_out_valid", 32'd0, 32'(out_valid));
        compare_val("reset_mem_req", 32'd0, 32'(mem_req));
        while (rst) begin
            @(posedge clk);
        end

        while (accepted < N_PKTS) begin
            // Values here are what the next rising edge will see.
            @(negedge clk);
            fire = out_valid && out_ready;
            pkt  = out_pkt;
            rd   = redirect;
            if (stalled) begin
                idle++;
            end
            if (fire) begin
                if (stalled) begin
                    abort_run("packet delivered after an indirect jump with no redirect");
                end
                w         = word_at(exp_pc);
                exp_instr = (w[1:0] != 2'b11) ? {16'h0, w[15:0]} : w;
                compare_val("pkt_pc", exp_pc, pkt.pc);
                compare_val("pkt_instr", exp_instr, pkt.instr);
                exp_pc  = model_next_pc(exp_pc, w, stall);
                stalled = stall;
                idle    = 0;
                accepted++;
            end
            if (rd.valid) begin
                exp_pc  = rd.target;
                stalled = 1'b0;
                idle    = 0;
            end

            @(posedge clk);
            out_ready <= stalled ? 1'b1 : ($urandom_range(1, 0) == 1);
            if (stalled && idle >= STALL_IDLE) begin
                redirect <= '{valid: 1'b1, target: pick_target()};
            end else if (!stalled && rand_redirs < N_RAND_REDIR
                         && $urandom_range(79, 0) == 0) begin
                redirect <= '{valid: 1'b1, target: pick_target()};
                rand_redirs++;
            end else begin
                redirect <= '0;
            end
        end

        $display(">>> PASS");
        $finish;
    end

    // Memory port handshake rules.
    initial begin
        logic        prev_req;
        logic [31:0] prev_addr;
        prev_req  = 1'b0;
        prev_addr = '0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (mem_req && !prev_req && mem_ack) begin
                    abort_run("mem_req rose while mem_ack was still high");
                end
                if (!mem_req && prev_req && !mem_ack) begin
                    abort_run("mem_req dropped before mem_ack was raised");
                end
                if (mem_req && prev_req) begin
                    compare_val("mem_addr_stable", prev_addr, mem_addr.addr);
                end
            end
            prev_req  = mem_req;
            prev_addr = mem_addr.addr;
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        abort_run("watchdog expired before all packets were checked");
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
`default_nettype none

module tb_mem_model #(
    parameter int MAX_DELAY = 5
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic [31:0] addr_word,
    output logic        mem_ack,
    output logic [31:0] mem_data
);

    int unsigned delay;
    logic        busy;

    // Each edge of the handshake is answered after 0 to MAX_DELAY extra cycles.
    initial begin
        mem_ack  = 1'b0;
        mem_data = '0;
        delay    = 0;
        busy     = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                mem_ack <= 1'b0;
                busy    <= 1'b0;
            end else if (mem_req != mem_ack) begin
                if (!busy) begin
                    busy  <= 1'b1;
                    delay <= $urandom_range(MAX_DELAY, 0);
                end else if (delay != 0) begin
                    delay <= delay - 1;
                end else begin
                    busy    <= 1'b0;
                    mem_ack <= mem_req;
                    if (mem_req) begin
                        mem_data <= addr_word;
                    end else begin
                        // Data is junk once ack is low.
                        mem_data <= $urandom();
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire
